// ==== Makefile ====
TOP = cpuControllerTb

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing -f filelist.f --top-module $(TOP)

# A run that aborts without a verdict counts as failed too
sim:
	verilator --binary --timing --assert -f filelist.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) > sim.log 2>&1 || echo "simulation exited with an error" >> sim.log
	cat sim.log
	! grep -q "TESTBENCH FAILED" sim.log
	grep -q "TESTBENCH PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== bench/cpuControllerChecker.sv ====
`timescale 1ns/1ns

module cpuControllerChecker (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                stall,
    input  logic [cpuCtrlPkg::opcodeWidth-1:0]  opcode,
    input  logic [cpuCtrlPkg::flagWidth-1:0]    flags,
    input  logic [1:0]                          memAddr,
    input  logic                                enPC, saveOpcode, saveMem1, enA, enB, enC,
    input  logic                                we, re, enF, sourceF, enSP, enFP,
    input  logic                                readStack, initSPFP,
    input  logic [3:0]                          aluFunc, aluA, aluB,
    input  logic [5:0]                          state,
    input  logic [127:0]                        testName,
    input  logic                                testDone,
    output int                                  testsRun,
    output int                                  testsFailed,
    output int                                  mismatches
);
    logic [27:0] actual;
    logic [33:0] predicted; // Next state above the 28 output bits
    logic [5:0]  expState;
    logic        expValid;
    int          testErrors;

    assign actual = {memAddr, enPC, saveOpcode, saveMem1, enA, enB, enC, we, re, enF, sourceF,
                     enSP, enFP, readStack, initSPFP, aluFunc, aluA, aluB};

    // Expected next state and outputs for one cycle
    function automatic logic [33:0] refModel(input logic [5:0] st, input logic [15:0] op,
                                             input logic [3:0] fl);
        logic [2:0] src;
        logic       imm, srcBad, isA, isI, isJ, isF, isPush, isPop, taken;
        logic       pc, so, sm, ea, eb, ec, w, r, ef, sf, esp, efp, rs, init;
        logic [5:0] first, nxt;
        logic [3:0] sel, func, a, b;
        logic [1:0] dst, addr;
        src = op[11:9];
        imm = (src == 3'b100);
        srcBad = (src > 3'd4);
        isA = (op[15:12] == 4'b0000) && !srcBad && !op[2];
        isI = (op[15:14] == 2'b01) && !src[2];
        isJ = (op[15:14] == 2'b11);
        isF = (op[15:12] == 4'b0010) && !op[8];
        taken = (fl[op[10:9]] == op[11]);
        isPush = (op[15:12] == 4'b0011) && (op[8:7] == 2'b00) && !srcBad;
        isPop = (op[15:12] == 4'b0011) && (op[8:7] == 2'b01) && !src[2];
        first = isA ? 6'd2 : isI ? 6'd3 : isJ ? 6'd4 : isF ? (taken ? 6'd6 : 6'd1) :
                isPush ? 6'd8 : isPop ? 6'd10 : 6'd63;
        sel = imm ? 4'd5 : {2'b00, src[1:0]}; // Memory word or register
        if (isI && src == 3'b000)
            sel = 4'd6; // SP
        dst = isA ? op[1:0] : src[1:0];
        {pc, so, sm, ea, eb, ec, w, r, ef, sf, esp, efp, rs, init} = 14'd0;
        addr = 2'd0;
        func = 4'd0;
        a = 4'd0;
        b = 4'd0;
        nxt = 6'd63;
        case (st)
            6'd0: begin
                {init, esp, efp} = 3'b111;
                nxt = 6'd1;
            end
            6'd1, 6'd20: begin
                r = 1'b1;
                so = (st == 6'd1);
                sm = (st == 6'd20);
                a = 4'd4; // PC + 1
                b = 4'd7;
                pc = 1'b1;
                nxt = (st == 6'd1 && (isA || isI || isPush) && imm) ? 6'd20 : first;
            end
            6'd2, 6'd3: begin
                a = sel;
                b = (st == 6'd2) ? {2'b00, op[4:3]} : 4'd8;
                func = (st == 6'd2) ? op[8:5] : {op[8], op[8], op[13:12]};
                ef = (st == 6'd2) ? |op : 1'b1;
                {ea, eb, ec} = {dst == 2'd1, dst == 2'd2, dst == 2'd3};
                esp = (st == 6'd3) && (dst == 2'd0);
                nxt = 6'd1;
            end
            6'd4, 6'd6: begin
                a = 4'd4;
                b = (st == 6'd4) ? 4'd9 : 4'd8;
                pc = 1'b1;
                nxt = 6'd1;
            end
            6'd8: begin
                a = sel;
                addr = 2'd1;
                {w, rs} = 2'b11;
                nxt = 6'd9;
            end
            6'd9: begin
                {a, b, func} = {4'd6, 4'd7, 4'd2}; // SP - 1
                esp = 1'b1;
                nxt = 6'd1;
            end
            6'd10: begin
                {a, b} = {4'd6, 4'd7};
                {esp, r, rs, sm} = 4'b1111;
                addr = 2'd2;
                nxt = 6'd11;
            end
            6'd11: begin
                a = 4'd5;
                {ea, eb, ec} = {dst == 2'd1, dst == 2'd2, dst == 2'd3};
                {ef, sf} = {2{dst == 2'd0}}; // Pop into flags
                nxt = 6'd1;
            end
            default: nxt = 6'd63;
        endcase
        return {nxt, addr, pc, so, sm, ea, eb, ec, w, r, ef, sf, esp, efp, rs, init, func, a, b};
    endfunction

    initial begin
        testsRun = 0;
        testsFailed = 0;
        mismatches = 0;
        testErrors = 0;
        expValid = 1'b0;
    end

    always @(posedge clk) begin
        if (rst) begin
            expState = 6'd0; // Reset forces START
            expValid = 1'b1;
        end else begin
            predicted = refModel(state, opcode, flags);
            if (expValid && state != expState) begin
                $display("[ERROR] %0s state expected %h actual %h", testName, expState, state);
                testErrors++;
            end
            if (!stall && predicted[27:0] != actual) begin
                $display("[ERROR] %0s outputs in state %0d expected %h actual %h", testName,
                         state, predicted[27:0], actual);
                testErrors++;
            end
            expState = stall ? state : predicted[33:28]; // Stall freezes the FSM
            expValid = 1'b1;
        end
        if (testDone) begin
            $display("%0s: %0s (%0d errors)", testName, testErrors == 0 ? "ok" : "mismatch",
                     testErrors);
            testsRun++;
            if (testErrors != 0)
                testsFailed++;
            mismatches += testErrors;
            testErrors = 0;
        end
    end

endmodule

// ==== bench/cpuControllerTb.sv ====
`timescale 1ns/1ns

module cpuControllerTb;
    localparam int testCount = 20;

    logic         clk = 1'b0;
    logic         rst, stall, testDone;
    logic [15:0]  opcode;
    logic [3:0]   flags;
    logic [1:0]   memAddr;
    logic         enPC, saveOpcode, saveMem1, enA, enB, enC, we, re, enF, sourceF;
    logic         enSP, enFP, readStack, initSPFP;
    logic [3:0]   aluFunc, aluA, aluB;
    logic [5:0]   state;
    logic [127:0] testName;
    logic [31:0]  r;
    integer       seed = 32'h1feb65d5;
    int           testsRun, testsFailed, mismatches;

    always #5 clk = ~clk;

    cpuController cpuController_i (.*);

    cpuControllerChecker checker_i (.*);

    // Ends in FETCH with stall high, so the next opcode is loaded before FETCH is left
    task automatic parkInFetch();
        stall <= 1'b1;
        testDone <= 1'b1;
        @(posedge clk);
        testDone <= 1'b0;
    endtask

    task automatic resetDut(input logic [127:0] name);
        testName <= name;
        rst <= 1'b1;
        stall <= 1'b0;
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk); // START to FETCH
        parkInFetch();
    endtask

    // Holds one instruction for a number of unstalled cycles
    task automatic runInstr(input logic [127:0] name, input logic [15:0] op,
                            input logic [3:0] fl, input int cycles, input bit randomStall);
        int n;
        bit s;
        n = 0;
        testName <= name;
        opcode <= op;
        flags <= fl;
        while (n < cycles) begin
            // Second state always stalls once, others at random
            s = randomStall && ((n == 1 && !s) || (($random(seed) & 3) == 0));
            stall <= s;
            @(posedge clk);
            if (!s)
                n++;
        end
        parkInFetch();
    endtask

    initial begin
        rst = 1'b1;
        stall = 1'b0;
        testDone = 1'b0;
        opcode = 16'h0000;
        flags = 4'h0;
        testName = "init";
        resetDut("reset");
        r = $random(seed);
        runInstr("aReg", {4'b0000, 1'b0, r[1:0], r[5:2], r[7:6], 1'b0, r[9:8]}, r[31:28], 2, 0);
        r = $random(seed);
        runInstr("aImm", {4'b0000, 3'b100, r[5:2], r[7:6], 1'b0, r[9:8]}, r[31:28], 3, 0);
        r = $random(seed);
        runInstr("iReg", {2'b01, r[1:0], 1'b0, r[3:2], r[12:4]}, r[31:28], 2, 0);
        r = $random(seed);
        runInstr("iSp", {2'b01, r[1:0], 3'b000, r[12:4]}, r[31:28], 2, 0);
        r = $random(seed);
        runInstr("jump", {2'b11, r[13:0]}, r[31:28], 2, 0);
        r = $random(seed);
        runInstr("fTaken", {4'b0010, r[4 + r[1:0]], r[1:0], 1'b0, r[15:8]}, r[7:4], 2, 0);
        r = $random(seed);
        runInstr("fSkip", {4'b0010, ~r[4 + r[1:0]], r[1:0], 1'b0, r[15:8]}, r[7:4], 1, 0);
        r = $random(seed);
        runInstr("push", {4'b0011, 1'b0, r[1:0], 2'b00, r[8:2]}, r[31:28], 3, 0);
        r = $random(seed);
        runInstr("pushImm", {4'b0011, 3'b100, 2'b00, r[8:2]}, r[31:28], 4, 0);
        r = $random(seed);
        runInstr("pop", {4'b0011, 1'b0, r[1:0], 2'b01, r[8:2]}, r[31:28], 3, 0);
        r = $random(seed);
        runInstr("popFlags", {4'b0011, 3'b000, 2'b01, r[8:2]}, r[31:28], 3, 0);
        r = $random(seed);
        runInstr("stallA", {4'b0000, 3'b100, r[5:2], r[7:6], 1'b0, r[9:8]}, r[31:28], 3, 1);
        r = $random(seed);
        runInstr("stallPush", {4'b0011, 1'b0, r[1:0], 2'b00, r[8:2]}, r[31:28], 3, 1);
        r = $random(seed);
        runInstr("badOpcode", {4'b0001, r[11:0]}, r[31:28], 4, 0); // HALT plus three cycles
        resetDut("haltReset1");
        r = $random(seed);
        runInstr("badSource", {4'b0000, 2'b11, r[0], r[9:1]}, r[31:28], 4, 0);
        resetDut("haltReset2");
        r = $random(seed);
        runInstr("badDest", {4'b0000, 1'b0, r[1:0], r[7:2], 1'b1, r[9:8]}, r[31:28], 4, 0);
        resetDut("haltReset3");
        @(negedge clk);
        $display("tests %0d, failing %0d, mismatches %0d, assertion failures %0d", testsRun,
                 testsFailed, mismatches, cpuController_i.props_i.failures);
        if (testsRun == testCount && testsFailed == 0 && mismatches == 0
            && cpuController_i.props_i.failures == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

    initial begin
        #(2 * (testCount * 8 * 10 + 8 * 10));
        $display("Timeout: the tests did not finish in time");
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

// ==== bench/cpuController_properties.sv ====
`timescale 1ns/1ns

module cpuController_properties (
    input logic       clk,
    input logic       rst,
    input logic       we,
    input logic       re,
    input logic       saveOpcode,
    input logic       saveMem1,
    input logic       enPC,
    input logic       enA,
    input logic       enB,
    input logic       enC,
    input logic       enF,
    input logic       enSP,
    input logic       enFP,
    input logic       readStack,
    input logic       initSPFP,
    input logic [5:0] state
);
    int failures = 0; // Count of failed assertions

    assert property (@(posedge clk) disable iff (rst) !(we && re))
        else begin $error("we and re high together"); failures++; end

    assert property (@(posedge clk) disable iff (rst) (state == 6'd63) |->
        !(enPC | enA | enB | enC | enF | enSP | enFP | we | re | saveOpcode | saveMem1
          | readStack | initSPFP))
        else begin $error("enable high in HALT"); failures++; end

    assert property (@(posedge clk) disable iff (rst) (state == 6'd63) |=> (state == 6'd63))
        else begin $error("HALT left without reset"); failures++; end

    assert property (@(posedge clk) disable iff (rst) saveOpcode |-> (state == 6'd1))
        else begin $error("saveOpcode outside FETCH"); failures++; end

endmodule

bind cpuController cpuController_properties props_i (.*);

// ==== common/cpuCtrlPkg.sv ====
package cpuCtrlPkg;

    localparam int opcodeWidth = 16; // Instruction word
    localparam int flagWidth = 4; // Flag register

    // Sequencer states, encoding shared with the debug port
    typedef enum logic [5:0] {
        START  = 6'd0,
        FETCH  = 6'd1,
        ATYPE  = 6'd2,
        ITYPE  = 6'd3,
        JTYPE  = 6'd4,
        FTYPE  = 6'd6,
        PUSH1  = 6'd8,
        PUSH2  = 6'd9,
        POP1   = 6'd10,
        POP2   = 6'd11,
        RIMMED = 6'd20, // Immediate operand read
        HALT   = 6'd63
    } stateT;

    typedef enum logic [2:0] {
        classA,
        classI,
        classJ,
        classF,
        classSkip, // F-type with false condition
        classPush,
        classPop,
        classInvalid
    } instrClassT;

    // ALU operand select, first four codes match the register field
    typedef enum logic [3:0] {
        srcZero = 4'd0,
        srcA    = 4'd1,
        srcB    = 4'd2,
        srcC    = 4'd3,
        srcPc,
        srcMem,
        srcSp,
        srcOne,
        srcOp,
        srcAddr
    } aluSrcT;

    typedef enum logic [1:0] {
        destNone = 2'd0,
        destA    = 2'd1,
        destB    = 2'd2,
        destC    = 2'd3
    } destT;

    typedef enum logic [1:0] {
        addrPc,
        addrSp,
        addrAlu
    } memAddrT;

    // Remaining function codes come straight from the instruction
    typedef enum logic [3:0] {
        aluAdd = 4'd0,
        aluSub = 4'd2
    } aluOpT;

endpackage

// ==== common/decodeIf.sv ====
`timescale 1ns/1ns

interface decodeIf;
    import cpuCtrlPkg::*;

    instrClassT instrClass;
    logic       srcImmediate; // Source field is 100
    aluSrcT     srcSel; // ALU input A for the instruction
    aluSrcT     operandB; // ALU input B for A-type and I-type
    destT       dest;
    aluOpT      aluOp;
    logic       updateFlags;

    modport decoder (
        output instrClass, srcImmediate, srcSel, operandB, dest, aluOp, updateFlags
    );

    modport sequencer (
        input instrClass, srcImmediate
    );

    modport outputs (
        input srcSel, operandB, dest, aluOp, updateFlags
    );

endinterface

// ==== filelist.f ====
common/cpuCtrlPkg.sv
common/decodeIf.sv
verilog/instrDecoder.sv
sequencer/controlSequencer.sv
sequencer/controlOutputs.sv
verilog/cpuController.sv
bench/cpuController_properties.sv
bench/cpuControllerChecker.sv
bench/cpuControllerTb.sv

// ==== sequencer/controlOutputs.sv ====
`timescale 1ns/1ns

module controlOutputs (
    input  cpuCtrlPkg::stateT   state,
    decodeIf.outputs            dec,
    output cpuCtrlPkg::memAddrT memAddr,
    output logic                enPC,
    output logic                saveOpcode,
    output logic                saveMem1,
    output logic                enA,
    output logic                enB,
    output logic                enC,
    output logic                we,
    output logic                re,
    output logic                enF,
    output logic                sourceF,
    output logic                enSP,
    output logic                enFP,
    output logic                readStack,
    output logic                initSPFP,
    output cpuCtrlPkg::aluOpT   aluFunc,
    output cpuCtrlPkg::aluSrcT  aluA,
    output cpuCtrlPkg::aluSrcT  aluB
);
    import cpuCtrlPkg::*;

    logic writeDest; // Register write selected by dest

    always_comb begin
        memAddr = addrPc;
        enPC = 1'b0;
        saveOpcode = 1'b0;
        saveMem1 = 1'b0;
        enA = 1'b0;
        enB = 1'b0;
        enC = 1'b0;
        we = 1'b0;
        re = 1'b0;
        enF = 1'b0;
        sourceF = 1'b0;
        enSP = 1'b0;
        enFP = 1'b0;
        readStack = 1'b0;
        initSPFP = 1'b0;
        aluFunc = aluAdd;
        aluA = srcZero;
        aluB = srcZero;
        writeDest = 1'b0;
        case (state)
            START: begin
                initSPFP = 1'b1;
                enSP = 1'b1;
                enFP = 1'b1;
            end
            FETCH, RIMMED: begin
                memAddr = addrPc; // Read word at PC
                re = 1'b1;
                saveOpcode = (state == FETCH);
                saveMem1 = (state == RIMMED);
                aluA = srcPc; // PC + 1
                aluB = srcOne;
                enPC = 1'b1;
            end
            ATYPE, ITYPE: begin
                aluA = dec.srcSel;
                aluB = dec.operandB;
                aluFunc = dec.aluOp;
                enF = dec.updateFlags;
                writeDest = 1'b1;
                if (state == ITYPE && dec.dest == destNone)
                    enSP = 1'b1; // I-type target 000 is SP
            end
            JTYPE, FTYPE: begin
                aluA = srcPc;
                aluB = (state == JTYPE) ? srcAddr : srcOp; // Address or offset
                enPC = 1'b1;
            end
            PUSH1: begin
                aluA = dec.srcSel; // Value + 0 onto the stack
                aluB = srcZero;
                memAddr = addrSp;
                we = 1'b1;
                readStack = 1'b1;
            end
            PUSH2: begin
                aluA = srcSp;
                aluB = srcOne;
                aluFunc = aluSub; // SP - 1
                enSP = 1'b1;
            end
            POP1: begin
                aluA = srcSp;
                aluB = srcOne;
                enSP = 1'b1; // SP + 1
                memAddr = addrAlu; // Read at the new SP
                re = 1'b1;
                readStack = 1'b1;
                saveMem1 = 1'b1;
            end
            POP2: begin
                aluA = srcMem; // Popped value passes through
                aluB = srcZero;
                writeDest = 1'b1;
                if (dec.dest == destNone) begin
                    enF = 1'b1; // Pop into flag register
                    sourceF = 1'b1;
                end
            end
            default: begin
            end
        endcase
        if (writeDest) begin
            case (dec.dest)
                destA: enA = 1'b1;
                destB: enB = 1'b1;
                destC: enC = 1'b1;
                default: begin
                end
            endcase
        end
    end

endmodule

// ==== sequencer/controlSequencer.sv ====
`timescale 1ns/1ns

module controlSequencer (
    input  logic              clk,
    input  logic              rst,
    input  logic              stall,
    decodeIf.sequencer        dec,
    output cpuCtrlPkg::stateT state
);
    import cpuCtrlPkg::*;

    stateT nextState;
    stateT classState; // First state of the decoded instruction

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= START;
        end else if (!stall) begin
            state <= nextState;
        end
    end

    always_comb begin
        case (dec.instrClass)
            classA:    classState = ATYPE;
            classI:    classState = ITYPE;
            classJ:    classState = JTYPE;
            classF:    classState = FTYPE;
            classSkip: classState = FETCH; // Condition false, next instruction
            classPush: classState = PUSH1;
            classPop:  classState = POP1;
            default:   classState = HALT;
        endcase
    end

    always_comb begin
        nextState = HALT; // Unknown state stops the CPU
        case (state)
            START: nextState = FETCH;
            FETCH: begin
                if (dec.srcImmediate)
                    nextState = RIMMED; // Operand word follows the instruction
                else
                    nextState = classState;
            end
            RIMMED: nextState = classState;
            ATYPE, ITYPE, JTYPE, FTYPE, PUSH2, POP2: nextState = FETCH;
            PUSH1: nextState = PUSH2;
            POP1: nextState = POP2;
            default: nextState = HALT; // HALT holds until reset
        endcase
    end

endmodule

// ==== verilog/cpuController.sv ====
`timescale 1ns/1ns

module cpuController (
    input  logic                                clk,
    input  logic                                rst,
    input  logic [cpuCtrlPkg::opcodeWidth-1:0]  opcode, // Held instruction
    input  logic [cpuCtrlPkg::flagWidth-1:0]    flags,
    input  logic                                stall,
    output cpuCtrlPkg::memAddrT                 memAddr,
    output logic                                enPC,
    output logic                                saveOpcode,
    output logic                                saveMem1,
    output logic                                enA,
    output logic                                enB,
    output logic                                enC,
    output logic                                we,
    output logic                                re,
    output logic                                enF,
    output logic                                sourceF,
    output logic                                enSP,
    output logic                                enFP,
    output logic                                readStack,
    output logic                                initSPFP,
    output cpuCtrlPkg::aluOpT                   aluFunc,
    output cpuCtrlPkg::aluSrcT                  aluA,
    output cpuCtrlPkg::aluSrcT                  aluB,
    output logic [5:0]                          state // Debug view of the FSM
);
    import cpuCtrlPkg::*;

    stateT curState;

    decodeIf decBus ();

    instrDecoder decoder_i (
        .opcode (opcode),
        .flags  (flags),
        .dec    (decBus.decoder)
    );

    controlSequencer sequencer_i (
        .clk   (clk),
        .rst   (rst),
        .stall (stall),
        .dec   (decBus.sequencer),
        .state (curState)
    );

    controlOutputs outputs_i (
        .state      (curState),
        .dec        (decBus.outputs),
        .memAddr    (memAddr),
        .enPC       (enPC),
        .saveOpcode (saveOpcode),
        .saveMem1   (saveMem1),
        .enA        (enA),
        .enB        (enB),
        .enC        (enC),
        .we         (we),
        .re         (re),
        .enF        (enF),
        .sourceF    (sourceF),
        .enSP       (enSP),
        .enFP       (enFP),
        .readStack  (readStack),
        .initSPFP   (initSPFP),
        .aluFunc    (aluFunc),
        .aluA       (aluA),
        .aluB       (aluB)
    );

    assign state = curState;

endmodule

// ==== verilog/instrDecoder.sv ====
`timescale 1ns/1ns

module instrDecoder (
    input  logic [cpuCtrlPkg::opcodeWidth-1:0] opcode,
    input  logic [cpuCtrlPkg::flagWidth-1:0]   flags,
    decodeIf.decoder                           dec
);
    import cpuCtrlPkg::*;

    logic [3:0] group;
    logic [2:0] srcField;
    logic [2:0] destField;
    logic       srcBad;
    logic       srcImm;
    logic       condTrue;
    logic       usesSrc;
    aluSrcT     srcReg;
    instrClassT cls;

    assign group = opcode[15:12]; // Instruction type nibble
    assign srcField = opcode[11:9]; // Source, or destination for I-type and pop
    assign destField = opcode[2:0];
    assign srcBad = srcField[2] & (srcField[1:0] != 2'b00); // Dropped read modes
    assign srcImm = (srcField == 3'b100);
    assign condTrue = (flags[opcode[10:9]] == opcode[11]);
    assign srcReg = srcImm ? srcMem : aluSrcT'({2'b00, srcField[1:0]});

    always_comb begin
        cls = classInvalid;
        usesSrc = 1'b0;
        dec.srcSel = srcReg;
        dec.operandB = srcOp;
        dec.dest = destNone;
        dec.aluOp = aluAdd;
        dec.updateFlags = 1'b0;
        if (group == 4'b0000) begin // A-type
            if (!srcBad && !destField[2])
                cls = classA;
            usesSrc = 1'b1;
            dec.operandB = aluSrcT'({2'b00, opcode[4:3]});
            dec.dest = destT'(destField[1:0]);
            dec.aluOp = aluOpT'(opcode[8:5]);
            dec.updateFlags = |opcode; // NOP leaves flags alone
        end else if (group[3:2] == 2'b01) begin // I-type
            if (!srcField[2]) // Field doubles as destination
                cls = classI;
            usesSrc = 1'b1;
            if (srcField == 3'b000)
                dec.srcSel = srcSp;
            dec.dest = destT'(srcField[1:0]);
            dec.aluOp = aluOpT'({opcode[8], opcode[8], opcode[13:12]});
            dec.updateFlags = 1'b1;
        end else if (group[3:2] == 2'b11) begin // J-type
            cls = classJ;
        end else if (group == 4'b0010 && !opcode[8]) begin // F-type
            cls = condTrue ? classF : classSkip;
        end else if (group == 4'b0011) begin
            if (opcode[8:7] == 2'b00) begin // Push
                if (!srcBad)
                    cls = classPush;
                usesSrc = 1'b1;
            end else if (opcode[8:7] == 2'b01) begin // Pop
                if (!srcField[2])
                    cls = classPop;
                dec.dest = destT'(srcField[1:0]);
            end
        end
    end

    assign dec.instrClass = cls;
    assign dec.srcImmediate = usesSrc & srcImm & (cls != classInvalid);

endmodule
